//--- common/adc_settings.svh
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

////////////////////
// SPI timing

// ctl_clk cycles per SCK half-period, 5 MHz SCK at 100 MHz
`define ADC_SPI_CLKDIV 10

////////////////////
// Power-on microcode

// ctl_clk cycles between microcode steps
`define ADC_STEP_INTERVAL 1024

// Lines in the init table
`define ADC_INIT_STEPS 14

`endif

//--- common/adc_types_pkg.sv
package adc_types_pkg;

	////////////////////
	// ADC register access

	typedef logic [7:0]  reg_addr_t;  // ADC register address
	typedef logic [15:0] reg_value_t; // Register contents

	// One register write, address byte goes out first
	typedef struct packed {
		reg_addr_t  addr;
		reg_value_t value;
	} reg_write_t;

	////////////////////
	// Power-on microcode

	// One microcode line, 27 bits
	typedef struct packed {
		logic       wr;    // Line carries a register write
		reg_write_t write;
		logic       rst_n; // ADC reset pin level
		logic       pd;    // ADC power-down pin level
	} init_step_t;

	typedef logic [3:0] step_index_t; // Microcode line number

	typedef enum logic [1:0] {
		SEQ_WAIT, // Before the first tick
		SEQ_RUN,  // Stepping through the table
		SEQ_DONE  // Table finished, host owns the bus
	} seq_state_t;

endpackage

//--- common/spi_types_pkg.sv
package spi_types_pkg;

	////////////////////
	// SPI datapath

	typedef logic [7:0] spi_byte_t;  // One byte on MOSI
	typedef logic [2:0] bit_count_t; // Bit within the byte
	typedef logic [7:0] div_count_t; // SCK half-period counter

	////////////////////
	// State machines

	typedef enum logic {
		SH_IDLE,
		SH_SHIFT
	} shift_state_t;

	// Named for the byte queued on leaving the state
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_ADDR,
		WR_HI,
		WR_LO,
		WR_END
	} wr_state_t;

endpackage

//--- spi/spi_shifter.sv
`timescale 1ns/1ns
`include "adc_settings.svh"

module spi_shifter (
	input logic ctl_clk,
	input logic reset,
	input logic shift_en,                   // Start strobe
	input spi_types_pkg::spi_byte_t tx_byte, // Taken with shift_en
	output logic spi_sck,
	output logic spi_mosi,
	output logic shift_done                 // One cycle after the last falling SCK
);

	localparam spi_types_pkg::div_count_t DIV_LAST =
		spi_types_pkg::div_count_t'(`ADC_SPI_CLKDIV - 1);

	spi_types_pkg::shift_state_t state;
	spi_types_pkg::div_count_t div_cnt; // Cycles into the half-period
	spi_types_pkg::bit_count_t bit_cnt; // Bits already sent
	spi_types_pkg::spi_byte_t shreg;    // MSB is the bit on the wire

	logic start;    // Accepted shift_en
	logic half_end; // Last cycle of a half-period
	logic sck_fall; // Falling SCK, next bit goes out

	assign start    = shift_en && (state == spi_types_pkg::SH_IDLE);
	assign half_end = (state == spi_types_pkg::SH_SHIFT) && (div_cnt == DIV_LAST);
	assign sck_fall = half_end && spi_sck;

	////////////////////
	// Control

	always_ff @(posedge ctl_clk) begin
		shift_done <= 1'b0;
		if (reset) begin
			state    <= spi_types_pkg::SH_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			spi_sck  <= 1'b0; // SPI mode 0, idle low
			spi_mosi <= 1'b0;
		end else if (start) begin
			state    <= spi_types_pkg::SH_SHIFT;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			spi_mosi <= tx_byte[7]; // MSB ahead of first rising edge
		end else if (state == spi_types_pkg::SH_SHIFT) begin
			div_cnt <= half_end ? '0 : div_cnt + 1'b1;
			if (half_end && !spi_sck) begin
				spi_sck <= 1'b1; // Slave samples here
			end else if (sck_fall) begin
				spi_sck <= 1'b0;
				if (bit_cnt == 3'd7) begin
					// Byte finished
					state      <= spi_types_pkg::SH_IDLE;
					spi_mosi   <= 1'b0;
					shift_done <= 1'b1;
				end else begin
					bit_cnt  <= bit_cnt + 1'b1;
					spi_mosi <= shreg[6]; // Next bit
				end
			end
		end
	end

	// Shift register, data only
	always_ff @(posedge ctl_clk) begin
		if (start)
			shreg <= tx_byte;
		else if (sck_fall)
			shreg <= {shreg[6:0], 1'b0};
	end

	// Writer waits for shift_done before queueing the next byte
	a_no_restart: assert property (@(posedge ctl_clk) disable iff (reset)
		shift_en |-> state == spi_types_pkg::SH_IDLE);

endmodule

//--- spi/reg_write_fsm.sv
`timescale 1ns/1ns

module reg_write_fsm (
	input logic ctl_clk,
	input logic reset,
	input logic reg_wr,                     // Start strobe
	input adc_types_pkg::reg_write_t wr_cmd, // Taken with reg_wr
	output logic spi_sck,
	output logic spi_mosi,
	output logic spi_cs_n,
	output logic wr_busy,                   // High from the cycle after reg_wr
	output logic wr_done                    // Pulse with cs_n rising
);

	spi_types_pkg::wr_state_t state;
	adc_types_pkg::reg_write_t cmd; // Latched command
	logic shift_en;
	logic shift_done;
	spi_types_pkg::spi_byte_t tx_byte;

	spi_shifter i_spi_shifter (
		.ctl_clk    (ctl_clk),
		.reset      (reset),
		.shift_en   (shift_en),
		.tx_byte    (tx_byte),
		.spi_sck    (spi_sck),
		.spi_mosi   (spi_mosi),
		.shift_done (shift_done)
	);

	assign wr_busy = (state != spi_types_pkg::WR_IDLE);

	// Byte offered to the shifter
	// shift_en is registered, so the state has already moved on when it fires
	always_comb begin
		case (state)
			spi_types_pkg::WR_HI:  tx_byte = cmd.addr;
			spi_types_pkg::WR_LO:  tx_byte = cmd.value[15:8];
			spi_types_pkg::WR_END: tx_byte = cmd.value[7:0];
			default:               tx_byte = cmd.addr;
		endcase
	end

	// Command latch
	always_ff @(posedge ctl_clk) begin
		if (reg_wr && !wr_busy)
			cmd <= wr_cmd;
	end

	////////////////////
	// Frame FSM

	always_ff @(posedge ctl_clk) begin
		shift_en <= 1'b0;
		wr_done  <= 1'b0;
		if (reset) begin
			state    <= spi_types_pkg::WR_IDLE;
			spi_cs_n <= 1'b1;
		end else begin
			case (state)
				spi_types_pkg::WR_IDLE: begin
					if (reg_wr) begin
						spi_cs_n <= 1'b0; // Open the frame
						state    <= spi_types_pkg::WR_ADDR;
					end
				end
				spi_types_pkg::WR_ADDR: begin
					shift_en <= 1'b1; // Address byte
					state    <= spi_types_pkg::WR_HI;
				end
				spi_types_pkg::WR_HI: begin
					if (shift_done) begin
						shift_en <= 1'b1; // Value, high byte
						state    <= spi_types_pkg::WR_LO;
					end
				end
				spi_types_pkg::WR_LO: begin
					if (shift_done) begin
						shift_en <= 1'b1; // Value, low byte
						state    <= spi_types_pkg::WR_END;
					end
				end
				spi_types_pkg::WR_END: begin
					if (shift_done) begin
						spi_cs_n <= 1'b1; // Close the frame
						wr_done  <= 1'b1;
						state    <= spi_types_pkg::WR_IDLE;
					end
				end
				default: state <= spi_types_pkg::WR_IDLE;
			endcase
		end
	end

	// Sequencer never overlaps two writes
	a_wr_idle: assert property (@(posedge ctl_clk) disable iff (reset)
		reg_wr |-> state == spi_types_pkg::WR_IDLE);

	// SCK only toggles inside a chip-select window
	a_sck_in_frame: assert property (@(posedge ctl_clk) disable iff (reset)
		spi_sck |-> !spi_cs_n);

endmodule

//--- source/interval_timer.sv
`timescale 1ns/1ns
`include "adc_settings.svh"

module interval_timer (
	input logic ctl_clk,
	input logic reset,
	input logic step_en,   // Count while high
	output logic step_tick // One cycle per interval
);

	localparam int CNT_W = $clog2(`ADC_STEP_INTERVAL);

	typedef logic [CNT_W-1:0] tick_count_t;

	localparam tick_count_t CNT_LAST = tick_count_t'(`ADC_STEP_INTERVAL - 1);

	tick_count_t count;

	always_ff @(posedge ctl_clk) begin
		step_tick <= 1'b0;
		if (reset || !step_en) begin
			count <= '0; // Restart interval when disabled
		end else if (count == CNT_LAST) begin
			count     <= '0;
			step_tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- source/init_rom.sv
`timescale 1ns/1ns

module init_rom (
	input adc_types_pkg::step_index_t step_index,
	output adc_types_pkg::init_step_t step
);

	// Pin levels only, no write
	function automatic adc_types_pkg::init_step_t pins(input logic rst_n, input logic pd);
		adc_types_pkg::init_step_t line;
		line       = '0;
		line.rst_n = rst_n;
		line.pd    = pd;
		return line;
	endfunction

	// Register write with pins at run levels
	function automatic adc_types_pkg::init_step_t regw(input adc_types_pkg::reg_addr_t addr,
		input adc_types_pkg::reg_value_t value);
		adc_types_pkg::init_step_t line;
		line             = pins(1'b1, 1'b0);
		line.wr          = 1'b1;
		line.write.addr  = addr;
		line.write.value = value;
		return line;
	endfunction

	always_comb begin
		case (step_index)
			4'd0:    step = pins(1'b0, 1'b0);       // Reset pulse
			4'd1:    step = pins(1'b1, 1'b0);
			4'd2:    step = pins(1'b1, 1'b1);       // Power-down pulse
			4'd3:    step = pins(1'b1, 1'b0);
			4'd4:    step = regw(8'h31, 16'h0001); // Single channel, no clock divide
			4'd5:    step = pins(1'b1, 1'b1);       // Power-down pulse
			4'd6:    step = pins(1'b1, 1'b0);
			4'd7:    step = regw(8'h3a, 16'h0202); // Input 1 on cores 1 and 2
			4'd8:    step = regw(8'h3b, 16'h0202); // Input 1 on cores 3 and 4
			4'd9:    step = regw(8'h53, 16'h0000);
			4'd10:   step = pins(1'b1, 1'b1);       // Power-down pulse
			4'd11:   step = pins(1'b1, 1'b0);
			4'd12:   step = regw(8'h56, 16'h0008);
			4'd13:   step = regw(8'h30, 16'h00ff);
			default: step = pins(1'b1, 1'b0);       // Run levels
		endcase
	end

endmodule

//--- source/init_sequencer.sv
`timescale 1ns/1ns
`include "adc_settings.svh"

module init_sequencer (
	input logic ctl_clk,
	input logic reset,
	input logic step_tick,
	input adc_types_pkg::init_step_t step,     // Line at step_index
	input logic wr_busy,
	input logic wr_done,
	input logic host_wr,
	input adc_types_pkg::reg_write_t host_cmd,
	output logic step_en,
	output adc_types_pkg::step_index_t step_index,
	output logic reg_wr,
	output adc_types_pkg::reg_write_t wr_cmd,
	output logic adc_pd,
	output logic adc_rst_n,
	output logic init_done,
	output logic host_busy
);

	localparam adc_types_pkg::step_index_t LAST_STEP =
		adc_types_pkg::step_index_t'(`ADC_INIT_STEPS - 1);

	adc_types_pkg::seq_state_t state;
	logic wr_pend; // From reg_wr until the writer reports done
	logic step_go; // Apply the current line
	logic host_go; // Accept a host write
	logic issue;   // Start a register write

	assign step_en   = (state != adc_types_pkg::SEQ_DONE);
	assign init_done = (state == adc_types_pkg::SEQ_DONE);
	assign host_busy = !init_done || wr_pend || wr_busy; // Covers the reg_wr cycle too

	assign step_go = step_tick && step_en;
	assign host_go = host_wr && !host_busy; // Strobes while busy are dropped
	assign issue   = (step_go && step.wr) || host_go;

	////////////////////
	// Microcode stepping

	always_ff @(posedge ctl_clk) begin
		if (reset) begin
			state      <= adc_types_pkg::SEQ_WAIT;
			step_index <= '0;
			adc_pd     <= 1'b0;
			adc_rst_n  <= 1'b1;
			reg_wr     <= 1'b0;
			wr_pend    <= 1'b0;
		end else begin
			reg_wr <= issue;
			if (issue)
				wr_pend <= 1'b1;
			else if (wr_done)
				wr_pend <= 1'b0;

			if (step_go) begin
				adc_pd    <= step.pd;
				adc_rst_n <= step.rst_n;
				if (step_index == LAST_STEP) begin
					state <= adc_types_pkg::SEQ_DONE; // Index parks on the last line
				end else begin
					step_index <= step_index + adc_types_pkg::step_index_t'(1);
					state      <= adc_types_pkg::SEQ_RUN;
				end
			end
		end
	end

	// Command to the writer, microcode first then host
	always_ff @(posedge ctl_clk) begin
		if (step_go)
			wr_cmd <= step.write;
		else if (host_go)
			wr_cmd <= host_cmd;
	end

	// Table has no line past the end
	a_index_range: assert property (@(posedge ctl_clk) disable iff (reset)
		step_index <= LAST_STEP);

endmodule

//--- source/adc_ctl_top.sv
`timescale 1ns/1ns

module adc_ctl_top (
	input logic ctl_clk,
	input logic reset,
	input logic host_wr,
	input adc_types_pkg::reg_write_t host_cmd,
	output logic spi_sck,
	output logic spi_mosi,
	output logic spi_cs_n,
	output logic adc_pd,
	output logic adc_rst_n,
	output logic init_done,
	output logic host_busy
);

	logic step_en;
	logic step_tick;
	logic reg_wr;
	logic wr_busy;
	logic wr_done;
	adc_types_pkg::step_index_t step_index;
	adc_types_pkg::init_step_t step;
	adc_types_pkg::reg_write_t wr_cmd;

	////////////////////
	// Power-on sequencing

	interval_timer i_interval_timer (
		.ctl_clk   (ctl_clk),
		.reset     (reset),
		.step_en   (step_en),
		.step_tick (step_tick)
	);

	init_rom i_init_rom (
		.step_index (step_index),
		.step       (step)
	);

	init_sequencer i_init_sequencer (
		.ctl_clk    (ctl_clk),
		.reset      (reset),
		.step_tick  (step_tick),
		.step       (step),
		.wr_busy    (wr_busy),
		.wr_done    (wr_done),
		.host_wr    (host_wr),
		.host_cmd   (host_cmd),
		.step_en    (step_en),
		.step_index (step_index),
		.reg_wr     (reg_wr),
		.wr_cmd     (wr_cmd),
		.adc_pd     (adc_pd),
		.adc_rst_n  (adc_rst_n),
		.init_done  (init_done),
		.host_busy  (host_busy)
	);

	////////////////////
	// SPI register writer

	reg_write_fsm i_reg_write_fsm (
		.ctl_clk  (ctl_clk),
		.reset    (reset),
		.reg_wr   (reg_wr),
		.wr_cmd   (wr_cmd),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.wr_busy  (wr_busy),
		.wr_done  (wr_done)
	);

endmodule

//--- verification/adc_ctl_tb.sv
`timescale 1ns/1ns
`include "adc_settings.svh"

module adc_ctl_tb;

	localparam int INIT_TIMEOUT  = (`ADC_INIT_STEPS + 4) * `ADC_STEP_INTERVAL;
	localparam int STEP_TIMEOUT  = 2 * `ADC_STEP_INTERVAL; // Gap between two power-on events
	localparam int FRAME_TIMEOUT = 64 * `ADC_SPI_CLKDIV + 16; // One frame plus margin
	localparam int HOST_WRITES   = 8;
	localparam logic [31:0] RNG_SEED = 32'h79e9_f46d;

	// One table line as the testbench sees it
	typedef struct packed {
		logic        wr;
		logic [7:0]  addr;
		logic [15:0] value;
		logic        rst_n;
		logic        pd;
	} table_line_t;

	// Observed or expected event on the ADC side
	typedef struct packed {
		logic        valid;
		logic        is_frame; // Else a pin change
		logic        pd;
		logic        rst_n;
		logic [23:0] frame;    // Address, value high, value low
	} tb_event_t;

	logic ctl_clk = 1'b0;
	logic reset;
	logic host_wr;
	adc_types_pkg::reg_write_t host_cmd;
	logic spi_sck, spi_mosi, spi_cs_n;
	logic adc_pd, adc_rst_n, init_done, host_busy;

	tb_event_t observed[$]; // From the monitor
	tb_event_t pending[$];  // Still to be seen in order

	adc_ctl_top i_adc_ctl_top (
		.ctl_clk   (ctl_clk),
		.reset     (reset),
		.host_wr   (host_wr),
		.host_cmd  (host_cmd),
		.spi_sck   (spi_sck),
		.spi_mosi  (spi_mosi),
		.spi_cs_n  (spi_cs_n),
		.adc_pd    (adc_pd),
		.adc_rst_n (adc_rst_n),
		.init_done (init_done),
		.host_busy (host_busy)
	);

	always #20 ctl_clk = ~ctl_clk; // 40 ns period

	////////////////////
	// Error reporting

	task automatic fail_out(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		fail_out($sformatf("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got));
	endtask

	////////////////////
	// Reference model

	// Power-on table in field order wr, addr, value, rst_n, pd
	function automatic table_line_t table_line(input int i);
		case (i)
			0:       return {1'b0, 8'h00, 16'h0000, 1'b0, 1'b0}; // ADC reset low
			1:       return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b0};
			2:       return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b1}; // Power down
			3:       return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b0};
			4:       return {1'b1, 8'h31, 16'h0001, 1'b1, 1'b0}; // Single channel
			5:       return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b1};
			6:       return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b0};
			7:       return {1'b1, 8'h3a, 16'h0202, 1'b1, 1'b0};
			8:       return {1'b1, 8'h3b, 16'h0202, 1'b1, 1'b0};
			9:       return {1'b1, 8'h53, 16'h0000, 1'b1, 1'b0};
			10:      return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b1};
			11:      return {1'b0, 8'h00, 16'h0000, 1'b1, 1'b0};
			12:      return {1'b1, 8'h56, 16'h0008, 1'b1, 1'b0};
			default: return {1'b1, 8'h30, 16'h00ff, 1'b1, 1'b0}; // Line 13
		endcase
	endfunction

	// k-th event of the power-on run or an invalid one past the end
	function automatic tb_event_t expected_event(input int k);
		table_line_t line;
		tb_event_t ev;
		logic pd;
		logic rst_n;
		int n;
		ev    = '0;
		pd    = 1'b0; // Levels out of reset
		rst_n = 1'b1;
		n     = 0;
		for (int i = 0; i < `ADC_INIT_STEPS; i++) begin
			line = table_line(i);
			if (line.pd != pd || line.rst_n != rst_n) begin
				if (n == k) begin
					ev.valid = 1'b1;
					ev.pd    = line.pd;
					ev.rst_n = line.rst_n;
					return ev;
				end
				n++;
			end
			pd    = line.pd;
			rst_n = line.rst_n;
			if (line.wr) begin
				if (n == k) begin
					ev.valid    = 1'b1;
					ev.is_frame = 1'b1;
					ev.frame    = {line.addr, line.value};
					return ev;
				end
				n++;
			end
		end
		return ev;
	endfunction

	////////////////////
	// Monitor for SPI frames and pin changes

	logic prev_sck, prev_cs_n, prev_pd, prev_rst_n, done_seen;
	logic [23:0] shift_in;
	int unsigned edge_cnt;

	always @(negedge ctl_clk) begin : monitor
		tb_event_t ev;
		if (reset) begin
			prev_sck   = 1'b0;
			prev_cs_n  = 1'b1;
			prev_pd    = 1'b0;
			prev_rst_n = 1'b1;
			done_seen  = 1'b0;
			edge_cnt   = 0;
		end else begin
			ev = '0;
			if (adc_pd != prev_pd || adc_rst_n != prev_rst_n) begin
				ev.valid = 1'b1;
				ev.pd    = adc_pd;
				ev.rst_n = adc_rst_n;
				observed.push_back(ev);
			end
			assert (!(spi_cs_n && spi_sck)) else fail_out("SCK high outside a chip-select window");
			if (!spi_cs_n && prev_cs_n) begin // Frame opens
				edge_cnt = 0;
				shift_in = '0;
			end
			if (spi_sck && !prev_sck && !spi_cs_n) begin // Slave sample point
				shift_in = {shift_in[22:0], spi_mosi};
				edge_cnt++;
			end
			if (spi_cs_n && !prev_cs_n) begin // Frame closes
				assert (edge_cnt == 24) else
					report_mismatch("sck_edges_per_frame", 32'd24, 32'(edge_cnt));
				ev.valid    = 1'b1;
				ev.is_frame = 1'b1;
				ev.frame    = shift_in;
				observed.push_back(ev);
			end
			assert (!done_seen || init_done) else fail_out("init_done fell after it had risen");
			done_seen  = done_seen || init_done;
			prev_sck   = spi_sck;
			prev_cs_n  = spi_cs_n;
			prev_pd    = adc_pd;
			prev_rst_n = adc_rst_n;
		end
	end

	////////////////////
	// Compare observed against pending

	// Runs half a cycle after the monitor has pushed its events
	always @(posedge ctl_clk) begin : compare
		tb_event_t got;
		tb_event_t exp;
		while (observed.size() != 0) begin
			got = observed.pop_front();
			assert (pending.size() != 0) else fail_out("unexpected pin change or SPI frame");
			exp = pending.pop_front();
			if (exp.is_frame) begin
				assert (got.is_frame) else fail_out("pin change seen where an SPI frame was due");
				assert (got.frame == exp.frame) else
					report_mismatch("spi_frame", 32'(exp.frame), 32'(got.frame));
			end else begin
				assert (!got.is_frame) else fail_out("SPI frame seen where a pin change was due");
				assert (got.pd == exp.pd) else report_mismatch("adc_pd", 32'(exp.pd), 32'(got.pd));
				assert (got.rst_n == exp.rst_n) else
					report_mismatch("adc_rst_n", 32'(exp.rst_n), 32'(got.rst_n));
			end
		end
	end

	////////////////////
	// Stimulus helpers

	task automatic next_cycle();
		@(posedge ctl_clk);
		#1; // Drive after the edge
	endtask

	task automatic wait_pending(input int left, input int limit, input string what);
		int waited;
		waited = 0;
		while (pending.size() > left) begin
			@(negedge ctl_clk);
			waited++;
			assert (waited < limit) else fail_out({"timeout waiting for ", what});
		end
	endtask

	task automatic wait_host_idle(input int limit);
		int waited;
		waited = 0;
		while (host_busy) begin
			@(negedge ctl_clk);
			waited++;
			assert (waited < limit) else fail_out("timeout waiting for host_busy to fall");
		end
	endtask

	function automatic adc_types_pkg::reg_write_t random_cmd();
		logic [31:0] r;
		r = $urandom;
		return r[23:0];
	endfunction

	// Queue the frame a host write should produce
	function automatic void expect_frame(input adc_types_pkg::reg_write_t cmd);
		tb_event_t ev;
		ev          = '0;
		ev.valid    = 1'b1;
		ev.is_frame = 1'b1;
		ev.frame    = cmd;
		pending.push_back(ev);
	endfunction

	////////////////////
	// Test sequence

	initial begin : stimulus
		adc_types_pkg::reg_write_t cmd;
		tb_event_t ev;
		int k;
		void'($urandom(RNG_SEED));
		reset    = 1'b1;
		host_wr  = 1'b0;
		host_cmd = '0;
		repeat (5) @(posedge ctl_clk);
		#1 reset = 1'b0;

		@(negedge ctl_clk); // Outputs still at reset values
		assert (spi_cs_n == 1'b1) else report_mismatch("spi_cs_n", 32'd1, 32'(spi_cs_n));
		assert (spi_sck == 1'b0) else report_mismatch("spi_sck", 32'd0, 32'(spi_sck));
		assert (spi_mosi == 1'b0) else report_mismatch("spi_mosi", 32'd0, 32'(spi_mosi));
		assert (adc_pd == 1'b0) else report_mismatch("adc_pd", 32'd0, 32'(adc_pd));
		assert (adc_rst_n == 1'b1) else report_mismatch("adc_rst_n", 32'd1, 32'(adc_rst_n));
		assert (init_done == 1'b0) else report_mismatch("init_done", 32'd0, 32'(init_done));
		assert (host_busy == 1'b1) else report_mismatch("host_busy", 32'd1, 32'(host_busy));

		// Whole power-on run
		k  = 0;
		ev = expected_event(0);
		while (ev.valid) begin
			pending.push_back(ev);
			k++;
			ev = expected_event(k);
		end
		wait_pending(1, INIT_TIMEOUT, "power-on pin changes and frames");
		// Last line not yet ticked
		assert (!init_done) else report_mismatch("init_done", 32'd0, 32'(init_done));
		wait_pending(0, STEP_TIMEOUT, "frame of the last power-on line");
		assert (init_done) else fail_out("init_done low after the last power-on event");
		wait_host_idle(FRAME_TIMEOUT);

		// Host writes one at a time
		for (int i = 0; i < HOST_WRITES; i++) begin
			wait_host_idle(FRAME_TIMEOUT);
			next_cycle();
			cmd = random_cmd();
			expect_frame(cmd);
			host_cmd = cmd;
			host_wr  = 1'b1;
			next_cycle();
			host_wr = 1'b0;
			wait_pending(0, FRAME_TIMEOUT, "host write frame");
		end

		// Second strobe while busy must vanish
		wait_host_idle(FRAME_TIMEOUT);
		next_cycle();
		cmd = random_cmd();
		expect_frame(cmd);
		host_cmd = cmd;
		host_wr  = 1'b1;
		next_cycle();
		host_wr = 1'b0;
		next_cycle();
		assert (host_busy) else fail_out("host_busy low right after an accepted host write");
		host_cmd = random_cmd();
		host_wr  = 1'b1;
		next_cycle();
		host_wr = 1'b0;
		wait_pending(0, FRAME_TIMEOUT, "frame of the accepted host write");
		wait_host_idle(FRAME_TIMEOUT);
		repeat (FRAME_TIMEOUT) begin // Long enough for a stray frame to finish
			@(negedge ctl_clk);
			assert (spi_cs_n) else fail_out("SPI frame started by a dropped host strobe");
		end
		next_cycle(); // Compare takes the last monitor sample
		assert (observed.size() == 0 && pending.size() == 0) else
			fail_out("extra SPI frame after the dropped host strobe");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/adc_types_pkg.sv
common/spi_types_pkg.sv
spi/spi_shifter.sv
spi/reg_write_fsm.sv
source/interval_timer.sv
source/init_rom.sv
source/init_sequencer.sv
source/adc_ctl_top.sv
verification/adc_ctl_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = adc_ctl_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
